//--- Bender.yml
package:
  name: hazard_unit

sources:
  - include_dirs:
      - source
    files:
      - source/hazardPkg.sv
      - source/forwardUnit.sv
      - source/branchUnit.sv
      - source/stallUnit.sv
      - source/hazardConfig.sv
      - source/hazardUnit.sv
      - target: test
        files:
          - verif/hazardUnitTb.sv

//--- build.f
+incdir+source
source/hazardPkg.sv
source/forwardUnit.sv
source/branchUnit.sv
source/stallUnit.sv
source/hazardConfig.sv
source/hazardUnit.sv
verif/hazardUnitTb.sv

//--- source/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module branchUnit (
    input  hazardPkg::branchInT  i_branch,
    output hazardPkg::branchResT o_branch
);

    logic flagN, flagZ, flagC, flagV;
    logic condTrue;
    logic isBranch;  // Branch or jump present
    logic taken;
    logic predTaken;
    logic mispredict;

    assign {flagN, flagZ, flagC, flagV} = i_branch.flags;

    ////////////////////////////////////////
    // Condition code check
    ////////////////////////////////////////

    always_comb begin
        case (i_branch.cond)
            4'd0:    condTrue = flagZ;                      // EQ
            4'd1:    condTrue = ~flagZ;                     // NE
            4'd2:    condTrue = flagC;                      // CS
            4'd3:    condTrue = ~flagC;                     // CC
            4'd4:    condTrue = flagN;                      // MI
            4'd5:    condTrue = ~flagN;                     // PL
            4'd6:    condTrue = flagV;                      // VS
            4'd7:    condTrue = ~flagV;                     // VC
            4'd8:    condTrue = flagC & ~flagZ;             // HI
            4'd9:    condTrue = ~flagC | flagZ;             // LS
            4'd10:   condTrue = (flagN == flagV);           // GE
            4'd11:   condTrue = (flagN != flagV);           // LT
            4'd12:   condTrue = ~flagZ & (flagN == flagV);  // GT
            4'd13:   condTrue = flagZ | (flagN != flagV);   // LE
            4'd14:   condTrue = 1'b1;                       // AL
            default: condTrue = 1'b0;                       // NV
        endcase
    end

    ////////////////////////////////////////
    // Resolution against the prediction
    ////////////////////////////////////////

    assign isBranch  = i_branch.branchInstr | i_branch.jumpInstr;
    assign taken     = i_branch.jumpInstr | (i_branch.branchInstr & condTrue);
    assign predTaken = i_branch.pcMatchValid & i_branch.ctrIn[1]; // Upper half means taken

    // Wrong direction, or right direction with a stale target
    // Nothing to resolve without a branch or jump
    assign mispredict = isBranch &
                        ((predTaken != taken) | (predTaken & taken & ~i_branch.targetMatch));

    always_comb begin
        o_branch.mispredict = mispredict;
        o_branch.tableWe    = isBranch; // Every resolved branch trains the table

        if (!isBranch) begin
            o_branch.npcSel = 2'd0;               // Sequential
        end else if (mispredict) begin
            o_branch.npcSel = taken ? 2'd1 : 2'd2; // Computed target or fall-through
        end else begin
            o_branch.npcSel = 2'd3;               // Prediction was right
        end

        // Counter training
        if (!i_branch.pcMatchValid) begin
            o_branch.ctrOut = taken ? `HZ_CTR_WEAK_T : `HZ_CTR_WEAK_NT; // New entry
        end else if (taken) begin
            o_branch.ctrOut = (i_branch.ctrIn == `HZ_CTR_MAX) ? `HZ_CTR_MAX
                                                             : i_branch.ctrIn + 1'b1;
        end else begin
            o_branch.ctrOut = (i_branch.ctrIn == `HZ_CTR_MIN) ? `HZ_CTR_MIN
                                                             : i_branch.ctrIn - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module forwardUnit (
    input  hazardPkg::idExT   i_idEx,
    input  hazardPkg::exMemT  i_exMem,
    input  hazardPkg::memWbT  i_memWb,
    input  logic              i_forwardEn,
    output hazardPkg::fwdResT o_fwd,
    output logic              o_needStall
);

    import hazardPkg::*;

    logic stallOp1; // Hazard on operand 1
    logic stallOp2; // Hazard on operand 2

    ////////////////////////////////////////
    // Per-operand source selection
    ////////////////////////////////////////

    function automatic fwdSelT pickSrc(
        input  logic                 need,
        input  logic [`HZ_REG_W-1:0] rs,
        input  exMemT                exMem,
        input  memWbT                memWb,
        input  logic                 fwdEn,
        output logic                 stall
    );
        logic   exHit;
        logic   wbHit;
        logic   isLoad;
        fwdSelT sel;

        // r0 is hardwired, never a real dependency
        exHit  = need && (rs != '0) && exMem.regWe && (exMem.rdst == rs);
        wbHit  = need && (rs != '0) && memWb.regWe && (memWb.rdst == rs);
        isLoad = exMem.memEnable && exMem.memRead; // Data not ready until MEM ends

        stall = 1'b0;
        sel   = FWD_REG;
        if (!fwdEn) begin
            // No bypass paths, wait for writeback
            stall = exHit || wbHit;
        end else if (exHit && isLoad) begin
            stall = 1'b1; // Load-use bubble
        end else if (exHit) begin
            sel = FWD_EXMEM; // Youngest writer wins
        end else if (wbHit) begin
            sel = FWD_MEMWB;
        end
        return sel;
    endfunction

    ////////////////////////////////////////
    // Both EX operands
    ////////////////////////////////////////

    always_comb begin
        o_fwd.op1Sel = pickSrc(i_idEx.needRs1, i_idEx.rs1, i_exMem, i_memWb,
                               i_forwardEn, stallOp1);
        o_fwd.op2Sel = pickSrc(i_idEx.needRs2, i_idEx.rs2, i_exMem, i_memWb,
                               i_forwardEn, stallOp2);
        o_needStall  = stallOp1 | stallOp2; // Either operand blocks ID
    end

endmodule

`default_nettype wire

//--- source/hazardConfig.sv
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module hazardConfig (
    input  logic                      i_clk,
    input  logic                      i_rstN,
    input  logic                      i_cfgWrite,     // One-cycle strobe
    input  logic                      i_cfgForwardEn,
    input  logic                      i_pcStall,      // From stall pattern
    output logic                      o_forwardEn,
    output logic [`HZ_STALLCNT_W-1:0] o_stallCount
);

    logic                      forwardEnQ;
    logic [`HZ_STALLCNT_W-1:0] stallCountQ;

    ////////////////////////////////////////
    // Forwarding enable
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            forwardEnQ <= 1'b1; // Bypass on by default
        end else if (i_cfgWrite) begin
            forwardEnQ <= i_cfgForwardEn;
        end
    end

    ////////////////////////////////////////
    // Stall cycle counter
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rstN) begin
        if (!i_rstN) begin
            stallCountQ <= '0;
        end else if (i_cfgWrite) begin
            stallCountQ <= '0; // Config write restarts the count
        end else if (i_pcStall && (stallCountQ != '1)) begin
            stallCountQ <= stallCountQ + 1'b1; // Sticks at all ones
        end
    end

    assign o_forwardEn  = forwardEnQ;
    assign o_stallCount = stallCountQ;

endmodule

`default_nettype wire

//--- source/hazardPkg.sv
`default_nettype none
`include "hazard_params.svh"

package hazardPkg;

    ////////////////////////////////////////
    // Pipeline stage fields
    ////////////////////////////////////////

    // Sources needed by the instr in ID/EX
    typedef struct packed {
        logic                 needRs1;
        logic                 needRs2;
        logic [`HZ_REG_W-1:0] rs1;
        logic [`HZ_REG_W-1:0] rs2;
    } idExT;

    // Writer in EX/MEM
    typedef struct packed {
        logic                 regWe;
        logic                 memEnable;
        logic                 memRead;  // Read when memEnable set
        logic [`HZ_REG_W-1:0] rdst;
        logic [1:0]           rdstSrc;  // 0 ALU, 1 load data, 2 link PC
    } exMemT;

    // Writer in MEM/WB
    typedef struct packed {
        logic                 regWe;
        logic [`HZ_REG_W-1:0] rdst;
    } memWbT;

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        FWD_REG   = 2'd0, // Register file value
        FWD_EXMEM = 2'd1, // EX/MEM result
        FWD_MEMWB = 2'd2  // MEM/WB result
    } fwdSelT;

    typedef struct packed {
        fwdSelT op1Sel;
        fwdSelT op2Sel;
    } fwdResT;

    ////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////

    typedef struct packed {
        logic                  pcMatchValid; // Predictor table hit
        logic                  branchInstr;
        logic                  jumpInstr;
        logic                  targetMatch;  // Predicted target == computed
        logic [`HZ_CTR_W-1:0]  ctrIn;
        logic [`HZ_COND_W-1:0] flags;        // NZCV
        logic [`HZ_COND_W-1:0] cond;
    } branchInT;

    typedef struct packed {
        logic [`HZ_CTR_W-1:0] ctrOut;
        logic                 tableWe;
        logic                 mispredict;
        logic [1:0]           npcSel;
    } branchResT;

    // Stall and flush per pipeline register
    typedef struct packed {
        logic pcStall;
        logic ifIdStall;
        logic idExStall;
        logic exMemStall;
        logic ifIdFlush;
        logic idExFlush;
        logic memWbFlush;
    } stallCtrlT;

endpackage

`default_nettype wire

//--- source/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module hazardUnit (
    input  logic                      i_clk,
    input  logic                      i_rstN,
    input  hazardPkg::idExT           i_idEx,
    input  hazardPkg::exMemT          i_exMem,
    input  hazardPkg::memWbT          i_memWb,
    input  hazardPkg::branchInT       i_branch,
    input  logic                      i_dCacheMiss,
    input  logic                      i_iCacheMiss,
    input  logic                      i_cfgWrite,
    input  logic                      i_cfgForwardEn,
    output hazardPkg::fwdResT         o_fwd,
    output hazardPkg::branchResT      o_branch,
    output hazardPkg::stallCtrlT      o_stall,
    output logic                      o_forwardEn,
    output logic [`HZ_STALLCNT_W-1:0] o_stallCount
);

    import hazardPkg::*;

    logic      forwardEn;
    logic      needStall;
    logic      mispredict;
    stallCtrlT stallPat;   // Raw pattern before branch flushes

    forwardUnit u_forwardUnit (
        .i_idEx      (i_idEx),
        .i_exMem     (i_exMem),
        .i_memWb     (i_memWb),
        .i_forwardEn (forwardEn),
        .o_fwd       (o_fwd),
        .o_needStall (needStall)
    );

    branchUnit u_branchUnit (
        .i_branch (i_branch),
        .o_branch (o_branch)
    );
    assign mispredict = o_branch.mispredict;

    stallUnit u_stallUnit (
        .i_needStall  (needStall),
        .i_dCacheMiss (i_dCacheMiss),
        .i_iCacheMiss (i_iCacheMiss),
        .o_stall      (stallPat)
    );

    hazardConfig u_hazardConfig (
        .i_clk          (i_clk),
        .i_rstN         (i_rstN),
        .i_cfgWrite     (i_cfgWrite),
        .i_cfgForwardEn (i_cfgForwardEn),
        .i_pcStall      (stallPat.pcStall), // Count cycles PC is held
        .o_forwardEn    (forwardEn),
        .o_stallCount   (o_stallCount)
    );

    ////////////////////////////////////////
    // Flush merge
    ////////////////////////////////////////

    always_comb begin
        o_stall           = stallPat;
        o_stall.ifIdFlush = stallPat.ifIdFlush | mispredict; // Kill wrong-path fetch
        o_stall.idExFlush = stallPat.idExFlush | mispredict; // Kill wrong-path decode
    end

    assign o_forwardEn = forwardEn;

endmodule

`default_nettype wire

//--- source/hazard_params.svh
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

////////////////////////////////////////
// Hazard unit widths
////////////////////////////////////////

// Register index, 32 architectural regs
`define HZ_REG_W 5

// Condition field and NZCV flags
`define HZ_COND_W 4

// Two-bit saturating predictor
`define HZ_CTR_W 2

// PC stall cycle counter
`define HZ_STALLCNT_W 16

// Predictor counter limits
`define HZ_CTR_MAX 2'd3
`define HZ_CTR_MIN 2'd0
`define HZ_CTR_WEAK_T 2'd2 // Init on miss, taken
`define HZ_CTR_WEAK_NT 2'd1 // Init on miss, not taken

`endif

//--- source/stallUnit.sv
`timescale 1ns/1ps
`default_nettype none

module stallUnit (
    input  logic                 i_needStall,  // Load-use or no-forward hazard
    input  logic                 i_dCacheMiss, // From D-cache in MEM
    input  logic                 i_iCacheMiss, // From I-cache in IF
    output hazardPkg::stallCtrlT o_stall
);

    ////////////////////////////////////////
    // Prioritised stall patterns
    ////////////////////////////////////////

    always_comb begin
        // Default is a free-running pipe
        o_stall.pcStall    = 1'b0;
        o_stall.ifIdStall  = 1'b0;
        o_stall.idExStall  = 1'b0;
        o_stall.exMemStall = 1'b0;
        o_stall.ifIdFlush  = 1'b0;
        o_stall.idExFlush  = 1'b0;
        o_stall.memWbFlush = 1'b0;

        if (i_dCacheMiss) begin
            // Freeze everything up to MEM
            o_stall.pcStall    = 1'b1;
            o_stall.ifIdStall  = 1'b1;
            o_stall.idExStall  = 1'b1;
            o_stall.exMemStall = 1'b1;
            o_stall.memWbFlush = 1'b1; // Bubble into WB
        end else if (i_needStall) begin
            // Hold fetch and decode
            o_stall.pcStall   = 1'b1;
            o_stall.ifIdStall = 1'b1;
            o_stall.idExFlush = 1'b1; // Bubble into EX
        end else if (i_iCacheMiss) begin
            o_stall.pcStall   = 1'b1;
            o_stall.ifIdFlush = 1'b1; // No valid fetch this cycle
        end
    end

    // Load-use loses to a D-cache miss since
    // the producing load is itself frozen in MEM

    // I-cache miss is lowest, later stages
    // can still drain while fetch waits

endmodule

`default_nettype wire

//--- verif/hazardUnitTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module hazardUnitTb;

    import hazardPkg::*;

    localparam int HALF_PERIOD = 4;   // 8 ns clock

    logic                      clk, rstN;
    idExT                      idEx;
    exMemT                     exMem;
    memWbT                     memWb;
    branchInT                  branchIn;
    logic                      dCacheMiss, iCacheMiss, cfgWrite, cfgForwardEn;
    fwdResT                    fwd;
    branchResT                 branchRes;
    stallCtrlT                 stall;
    logic                      forwardEn;
    logic [`HZ_STALLCNT_W-1:0] stallCount;

    // Golden file fields
    integer                    fd, nRead, vecNo;
    integer                    rs1, rs2, exRd, wbRd, cond, sel1, sel2, npc;
    logic [8*8-1:0]            kind;
    logic [8*256-1:0]          skipBuf;
    logic [1:0]                need, ctr, miss, expCtr; // Need bits rs1 rs2 and miss bits D I
    logic [2:0]                exCtl;                   // regWe memEnable memRead
    logic [3:0]                brCtl, nzcv;             // hit branch jump targetMatch
    logic                      wbWe, expWe, expMis, cfgVal;
    logic [6:0]                expStallBits;
    logic [`HZ_STALLCNT_W-1:0] expCount, modelCount;    // Model built from expected pcStall
    fwdResT                    expFwd;
    branchResT                 expBranch;
    stallCtrlT                 expStall;

    hazardUnit u_hazardUnit (
        .i_clk          (clk),
        .i_rstN         (rstN),
        .i_idEx         (idEx),
        .i_exMem        (exMem),
        .i_memWb        (memWb),
        .i_branch       (branchIn),
        .i_dCacheMiss   (dCacheMiss),
        .i_iCacheMiss   (iCacheMiss),
        .i_cfgWrite     (cfgWrite),
        .i_cfgForwardEn (cfgForwardEn),
        .o_fwd          (fwd),
        .o_branch       (branchRes),
        .o_stall        (stall),
        .o_forwardEn    (forwardEn),
        .o_stallCount   (stallCount)
    );

    always #HALF_PERIOD clk = ~clk;

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic checkFwd(input fwdResT got, input fwdResT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: vector %0d forwarding op1 %0d op2 %0d, expected %0d %0d",
                     $time, vecNo, got.op1Sel, got.op2Sel, exp.op1Sel, exp.op2Sel);
            $display("Test failures found");
            $fatal(1, "Forwarding select mismatch");
        end
    endtask

    task automatic checkBranch(input branchResT got, input branchResT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: vector %0d branch ctr/we/mis/npc %b, expected %b",
                     $time, vecNo, got, exp);
            $display("Test failures found");
            $fatal(1, "Branch result mismatch");
        end
    endtask

    task automatic checkStall(input stallCtrlT got, input stallCtrlT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: vector %0d stall/flush %b, expected %b",
                     $time, vecNo, got, exp);
            $display("Test failures found");
            $fatal(1, "Stall pattern mismatch");
        end
    endtask

    task automatic checkCount(input logic [`HZ_STALLCNT_W-1:0] got,
                              input logic [`HZ_STALLCNT_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "Stall count mismatch");
        end
    endtask

    task automatic checkEnable(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: forwarding enable %s is %0b, expected %0b",
                     $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "Forwarding enable mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic driveIdle();
        idEx       = '0;
        exMem      = '0;
        memWb      = '0;
        branchIn   = '0;
        dCacheMiss = 1'b0;
        iCacheMiss = 1'b0;
    endtask

    task automatic expectFields(input integer got, input integer want);
        if (got != want) begin
            $display("Test failures found");
            $fatal(1, "Golden file entry after vector %0d is malformed", vecNo);
        end
    endtask

    task automatic applyVector();
        @(negedge clk);
        idEx            = '{need[1], need[0], rs1[`HZ_REG_W-1:0], rs2[`HZ_REG_W-1:0]};
        exMem.regWe     = exCtl[2];
        exMem.memEnable = exCtl[1];
        exMem.memRead   = exCtl[0];
        exMem.rdst      = exRd[`HZ_REG_W-1:0];
        exMem.rdstSrc   = exCtl[0] ? 2'd1 : 2'd0; // Loads return memory data
        memWb           = '{wbWe, wbRd[`HZ_REG_W-1:0]};
        branchIn        = '{brCtl[3], brCtl[2], brCtl[1], brCtl[0], ctr, nzcv, cond[3:0]};
        dCacheMiss      = miss[1];
        iCacheMiss      = miss[0];
        expFwd          = '{fwdSelT'(sel1[1:0]), fwdSelT'(sel2[1:0])};
        expBranch       = '{expCtr, expWe, expMis, npc[1:0]};
        expStall        = expStallBits;
        #(HALF_PERIOD - 1); // Sample just before the rising edge
        vecNo++;
        checkFwd(fwd, expFwd);
        checkBranch(branchRes, expBranch);
        checkStall(stall, expStall);
        if (expStall.pcStall)
            modelCount = modelCount + 1'b1; // Counted at the coming edge
    endtask

    task automatic writeConfig(input logic val);
        @(negedge clk);
        driveIdle();
        cfgWrite     = 1'b1;
        cfgForwardEn = val;
        @(negedge clk);
        cfgWrite   = 1'b0;
        modelCount = '0; // Write clears the count
        checkEnable(forwardEn, val, "after config write");
    endtask

    task automatic verifyStallCount();
        @(negedge clk);
        driveIdle();
        #(HALF_PERIOD - 1);
        checkCount(modelCount, expCount, "golden count vs vector history");
        checkCount(stallCount, modelCount, "DUT stall count");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        cfgWrite     = 1'b0;
        cfgForwardEn = 1'b0;
        driveIdle();
        vecNo      = 0;
        modelCount = '0;
        fd = $fopen("verif/hazard_golden.txt", "r");
        if (fd == 0) begin
            $display("Test failures found");
            $fatal(1, "Cannot open verif/hazard_golden.txt");
        end
        repeat (10) @(posedge clk); // Reset held 10 cycles
        @(negedge clk);
        rstN = 1'b1;
        checkEnable(forwardEn, 1'b1, "after reset"); // Bypass on out of reset

        while ($fscanf(fd, " %s", kind) == 1) begin
            if (kind == "#") begin
                nRead = $fgets(skipBuf, fd); // Column notes
            end else if (kind == "V") begin
                nRead = $fscanf(fd, " %b %d %d %b %d %b %d %b %b %b %d %b %d %d %b %b %b %d %b",
                                need, rs1, rs2, exCtl, exRd, wbWe, wbRd, brCtl, ctr, nzcv,
                                cond, miss, sel1, sel2, expCtr, expWe, expMis, npc,
                                expStallBits);
                expectFields(nRead, 19);
                applyVector();
            end else if (kind == "C") begin
                nRead = $fscanf(fd, " %b", cfgVal);
                expectFields(nRead, 1);
                writeConfig(cfgVal);
            end else if (kind == "S") begin
                nRead = $fscanf(fd, " %d", expCount);
                expectFields(nRead, 1);
                verifyStallCount();
            end else begin
                $display("Test failures found");
                $fatal(1, "Unknown entry kind in golden file after vector %0d", vecNo);
            end
        end
        $fclose(fd);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/hazard_golden.txt
# V need rs1 rs2 exCtl(we,en,rd) exRd wbWe wbRd br(hit,br,jmp,tm) ctr nzcv cond miss(d,i)
#   then sel1 sel2 ctrOut tableWe mispredict npcSel stall(pc,ifId,idEx,exMem,ifIdF,idExF,wbF)
# C forwardEn ; S expected stall count
S 0
V 11 3 4 100 3 1 4 0100 00 0100 0 00 1 2 10 1 1 1 0000110
V 11 5 5 100 5 1 5 0100 00 0100 1 00 1 1 01 1 0 3 0000000
V 11 0 0 100 0 1 0 0100 00 0010 2 00 0 0 10 1 1 1 0000110
V 11 6 7 000 6 0 7 0100 00 0010 3 00 0 0 01 1 0 3 0000000
V 00 8 8 100 8 1 8 0100 00 1000 4 00 0 0 10 1 1 1 0000110
V 10 9 2 111 9 0 0 0100 00 0000 5 00 0 0 10 1 1 1 1100110
V 11 10 11 111 11 1 10 0100 00 0000 6 00 2 0 01 1 0 3 1100010
S 2
C 0
V 11 3 4 100 3 1 4 0100 00 0001 7 00 0 0 01 1 0 3 1100010
V 11 0 0 100 0 1 0 0100 00 0110 8 00 0 0 01 1 0 3 0000000
S 1
C 1
V 11 5 5 100 5 1 5 0100 00 0110 9 00 1 1 10 1 1 1 0000110
S 0
V 10 9 0 111 9 0 0 0100 00 1001 10 11 0 0 10 1 1 1 1111111
V 10 9 0 111 9 0 0 0100 00 1000 11 01 0 0 10 1 1 1 1100110
V 00 0 0 000 0 0 0 0100 00 1101 12 01 0 0 01 1 0 3 1000100
V 00 0 0 000 0 0 0 0100 00 0001 13 10 0 0 10 1 1 1 1111111
S 4
V 00 0 0 000 0 0 0 1101 11 0000 14 00 0 0 11 1 0 3 0000000
V 00 0 0 000 0 0 0 1100 11 0000 14 00 0 0 11 1 1 1 0000110
V 00 0 0 000 0 0 0 1101 10 1111 15 00 0 0 01 1 1 2 0000110
V 00 0 0 000 0 0 0 1100 00 1111 15 00 0 0 00 1 0 3 0000000
V 00 0 0 000 0 0 0 1011 01 0000 15 00 0 0 10 1 1 1 0000110
V 00 0 0 000 0 0 0 1101 10 0000 14 00 0 0 11 1 0 3 0000000
V 00 0 0 000 0 0 0 0000 00 0000 0 00 0 0 01 0 0 0 0000000
S 4
